// ==== all.f ====
src/dec_pkg.sv
src/dec_slot_if.sv
src/dec_dbg_xlate.sv
src/dec_ib_ctl.sv
src/dec_instr_decode.sv
src/dec_gpr.sv
src/dec_csr.sv
src/dec_alu.sv
src/dec_top.sv
test/tb_dec.sv

// ==== src/dec_alu.sv ====
// D-stage datapath
// rs1 source select (register or debug write data) and or / csr result mux
`timescale 1ns/10ps

module dec_alu #(
   parameter int XLEN = 32
) (
   dec_slot_if.dec         slot,
   input  logic [XLEN-1:0] rs1_data,
   input  logic [XLEN-1:0] rs2_data,
   input  logic [XLEN-1:0] csr_rdata,
   input  logic            sel_csr,
   output logic [XLEN-1:0] rs1_val,    // also the csr write data
   output logic [XLEN-1:0] result
);

   // halted core, a debug write rides in on rs1
   assign rs1_val = slot.wdata_rs1 ? slot.wdata : rs1_data;

   always_comb begin
      if (sel_csr)
         result = csr_rdata;           // csr ops return the old value
      else
         result = rs1_val | rs2_data;  // or, also the gpr read/write path
   end

endmodule

// ==== src/dec_csr.sv ====
// small csr file
// mscratch, mepc, dcsr, dpc; debug fence detection on 0x7c4
`timescale 1ns/10ps

module dec_csr #(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic [11:0]     addr,
   input  logic            we,
   input  logic            re,
   input  logic [XLEN-1:0] wdata,
   output logic [XLEN-1:0] rdata,
   output logic            dfence_hit
);
   import dec_pkg::*;

   logic [XLEN-1:0] mscratch;
   logic [XLEN-1:0] mepc;
   logic [XLEN-1:0] dcsr;
   logic [XLEN-1:0] dpc;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mscratch <= '0;
         mepc     <= '0;
         dcsr     <= '0;
         dpc      <= '0;
      end else if (we) begin
         case (addr)
            CSR_MSCRATCH: mscratch <= wdata;
            CSR_MEPC:     mepc     <= wdata;
            CSR_DCSR:     dcsr     <= wdata;
            CSR_DPC:      dpc      <= wdata;
            default: ;                       // unknown address, write dropped
         endcase
      end
   end

   always_comb begin
      rdata = '0;  // unknown csr, and no read, give zero
      if (re) begin
         case (addr)
            CSR_MSCRATCH: rdata = mscratch;
            CSR_MEPC:     rdata = mepc;
            CSR_DCSR:     rdata = dcsr;
            CSR_DPC:      rdata = dpc;
            default:      rdata = '0;
         endcase
      end
   end

   assign dfence_hit = we & (addr == CSR_DFENCE);  // pulse only, nothing stored

endmodule

// ==== src/dec_dbg_xlate.sv ====
// debug abstract command to instruction translation
// gpr/csr reads and writes become or / csrrs / csrrw, memory commands are flagged
`timescale 1ns/10ps

module dec_dbg_xlate (
   input  logic               dbg_cmd_valid,
   input  logic               dbg_cmd_write,
   input  dec_pkg::dbg_type_e dbg_cmd_type,
   input  logic [11:0]        dbg_cmd_addr,
   output logic               dbg_take,        // command goes into the decode slot
   output dec_pkg::instr_u    dbg_instr,
   output logic               dbg_wdata_rs1,   // writes carry their data on rs1
   output logic               dbg_unsupported  // memory command, rejected
);
   import dec_pkg::*;

   logic [4:0] dreg;

   assign dreg = dbg_cmd_addr[4:0];  // gpr index is the low bits

   assign dbg_take        = dbg_cmd_valid & (dbg_cmd_type != MEM);
   assign dbg_unsupported = dbg_cmd_valid & (dbg_cmd_type == MEM);
   assign dbg_wdata_rs1   = dbg_take & dbg_cmd_write;

   always_comb begin
      dbg_instr.word = '0;  // undefined types decode as illegal
      case (dbg_cmd_type)
         GPR: begin
            dbg_instr.r.opcode = OPC_OP;
            dbg_instr.r.funct3 = F3_OR;
            if (dbg_cmd_write)
               dbg_instr.r.rd = dreg;   // or reg, x0, x0 with data forced on rs1
            else
               dbg_instr.r.rs1 = dreg;  // or x0, reg, x0
         end
         CSR: begin
            dbg_instr.c.opcode = OPC_SYSTEM;
            dbg_instr.c.csr    = dbg_cmd_addr;
            // rd and rs1 stay x0, old value comes back through the result path
            dbg_instr.c.funct3 = dbg_cmd_write ? F3_CSRRW : F3_CSRRS;
         end
         default: ;
      endcase
   end

endmodule

// ==== src/dec_gpr.sv ====
// integer register file
// 31 storage entries, x0 hardwired to zero, two async reads, one sync write
`timescale 1ns/10ps

module dec_gpr #(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic [4:0]      rs1_addr,
   input  logic [4:0]      rs2_addr,
   input  logic [4:0]      rd_addr,
   input  logic            we,
   input  logic [XLEN-1:0] wdata,
   output logic [XLEN-1:0] rs1_data,
   output logic [XLEN-1:0] rs2_data
);

   logic [XLEN-1:0] regs [1:31];  // no entry for x0

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (rd_addr != 5'd0)) begin
         regs[rd_addr] <= wdata;  // visible to reads from the next cycle on
      end
   end

   // x0 reads back zero whatever was written
   assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== src/dec_ib_ctl.sv ====
// decode slot control
// picks debug over fetch, registers the slot, drives retire and debug response strobes
`timescale 1ns/10ps

module dec_ib_ctl #(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            ifu_valid,
   input  logic [31:0]     ifu_instr,
   input  logic [31:1]     ifu_pc,
   input  logic            ifu_pc4,
   input  logic            ifu_icaf,
   input  logic            ifu_dbecc,
   input  logic            dbg_take,
   input  dec_pkg::instr_u dbg_instr,
   input  logic            dbg_wdata_rs1,
   input  logic            dbg_unsupported,
   input  logic [XLEN-1:0] dbg_wdata,
   input  logic            illegal,           // from decode of the current slot
   input  logic            dfence_hit,        // csr saw a write to the fence address
   dec_slot_if.ctl         slot,
   output logic            ret_valid,
   output logic [31:1]     ret_pc,
   output logic            ret_fault,
   output logic            ret_illegal,
   output logic            dbg_resp_valid,
   output logic            dbg_fence,
   output logic            dbg_unsupported_d
);

   // control side of the slot
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         slot.valid        <= 1'b0;
         slot.debug        <= 1'b0;
         slot.fault        <= 1'b0;
         slot.wdata_rs1    <= 1'b0;
         dbg_unsupported_d <= 1'b0;
      end else begin
         slot.valid        <= dbg_take | ifu_valid;        // debug wins, fetch is dropped
         slot.debug        <= dbg_take;
         slot.fault        <= ~dbg_take & ifu_valid & (ifu_icaf | ifu_dbecc);
         slot.wdata_rs1    <= dbg_take & dbg_wdata_rs1;
         dbg_unsupported_d <= dbg_unsupported;             // lines up with the response cycle
      end
   end

   // payload side
   always_ff @(posedge clk) begin
      slot.instr.word <= dbg_take ? dbg_instr.word : ifu_instr;
      slot.pc         <= ifu_pc;
      slot.pc4        <= ifu_pc4;
      slot.wdata      <= dbg_wdata;
   end

   assign ret_valid      = slot.valid & ~slot.debug;
   assign ret_pc         = slot.pc;
   assign ret_fault      = ret_valid & slot.fault;
   assign ret_illegal    = ret_valid & ~slot.fault & illegal;  // a fault takes precedence
   assign dbg_resp_valid = slot.valid & slot.debug;
   assign dbg_fence      = dbg_resp_valid & dfence_hit;

endmodule

// ==== src/dec_instr_decode.sv ====
// D-stage decoder
// views the slot word as r-type or csr type, produces gpr/csr controls and illegal
`timescale 1ns/10ps

module dec_instr_decode (
   dec_slot_if.dec slot,
   output logic [4:0]  rs1_addr,
   output logic [4:0]  rs2_addr,
   output logic [4:0]  rd_addr,
   output logic        gpr_we,
   output logic [11:0] csr_addr,
   output logic        csr_we,
   output logic        csr_re,
   output logic        sel_csr,   // result comes from the csr old value
   output logic        illegal
);
   import dec_pkg::*;

   logic is_sys;
   logic is_or;
   logic is_csrrw;
   logic is_csrrs;
   logic ok;

   assign is_sys = (slot.instr.c.opcode == OPC_SYSTEM);

   // r-type view
   assign is_or = (slot.instr.r.opcode == OPC_OP) &
                  (slot.instr.r.funct3 == F3_OR) &
                  (slot.instr.r.funct7 == 7'd0);

   // csr view
   assign is_csrrw = is_sys & (slot.instr.c.funct3 == F3_CSRRW);
   assign is_csrrs = is_sys & (slot.instr.c.funct3 == F3_CSRRS);

   // rs1 and rd sit in the same bits in both views
   assign rs1_addr = slot.instr.r.rs1;
   assign rd_addr  = slot.instr.r.rd;

   assign rs2_addr = is_sys ? 5'd0 : slot.instr.r.rs2;  // csr ops have no rs2
   assign csr_addr = slot.instr.c.csr;

   assign ok = slot.valid & ~slot.fault;  // faulted fetches never update state

   assign sel_csr = is_csrrw | is_csrrs;
   assign gpr_we  = ok & (is_or | sel_csr) & (rd_addr != 5'd0);  // x0 stays zero
   assign csr_re  = ok & sel_csr;
   assign csr_we  = ok & (is_csrrw | (is_csrrs & (rs1_addr != 5'd0)));  // csrrs x0 reads only

   assign illegal = ~(is_or | is_csrrw | is_csrrs);

endmodule

// ==== src/dec_pkg.sv ====
// shared decode definitions
// instruction word union (r-type and csr views), debug command type,
// opcode / funct3 constants and csr addresses
package dec_pkg;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } rtype_t;

   typedef struct packed {
      logic [11:0] csr;       // csr number sits where funct7/rs2 would be
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } csrtype_t;

   // one 32-bit word, decoded either way depending on opcode
   typedef union packed {
      logic [31:0] word;
      rtype_t      r;
      csrtype_t    c;
   } instr_u;

   typedef enum logic [1:0] {
      GPR = 2'd0,
      CSR = 2'd1,
      MEM = 2'd2              // abstract memory access, not handled here
   } dbg_type_e;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   localparam logic [2:0] F3_OR    = 3'b110;
   localparam logic [2:0] F3_CSRRW = 3'b001;
   localparam logic [2:0] F3_CSRRS = 3'b010;

   localparam logic [11:0] CSR_MSCRATCH = 12'h340;
   localparam logic [11:0] CSR_MEPC     = 12'h341;
   localparam logic [11:0] CSR_DCSR     = 12'h7b0;
   localparam logic [11:0] CSR_DPC      = 12'h7b1;
   localparam logic [11:0] CSR_DFENCE   = 12'h7c4;  // debug-only fence, no storage

endpackage

// ==== src/dec_slot_if.sv ====
// decode slot bundle between the control block and the D-stage consumers
// ctl modport fills the slot, dec modport reads it
`timescale 1ns/10ps

interface dec_slot_if #(
   parameter int XLEN = 32
);
   import dec_pkg::*;

   logic            valid;      // slot holds an item this cycle
   logic            debug;      // item came from a debug command
   instr_u          instr;
   logic [31:1]     pc;
   logic            pc4;        // carried along, no compressed expansion
   logic            fault;      // icaf or dbecc on the fetch
   logic            wdata_rs1;  // steer debug write data onto rs1
   logic [XLEN-1:0] wdata;

   modport ctl (output valid, debug, instr, pc, pc4, fault, wdata_rs1, wdata);
   modport dec (input  valid, debug, instr, pc, pc4, fault, wdata_rs1, wdata);

endinterface

// ==== src/dec_top.sv ====
// decode front end top level
// debug translation, slot control, decoder, register file, csr file and datapath
`timescale 1ns/10ps

module dec_top #(
   parameter int XLEN = 32
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            ifu_valid,
   input  logic [31:0]     ifu_instr,
   input  logic [31:1]     ifu_pc,
   input  logic            ifu_pc4,
   input  logic            ifu_icaf,
   input  logic            ifu_dbecc,
   input  logic            dbg_cmd_valid,
   input  logic            dbg_cmd_write,
   input  logic [1:0]      dbg_cmd_type,
   input  logic [11:0]     dbg_cmd_addr,
   input  logic [XLEN-1:0] dbg_wdata,
   output logic            dbg_resp_valid,
   output logic [XLEN-1:0] dbg_rdata,
   output logic            dbg_fence,
   output logic            dbg_unsupported,
   output logic            ret_valid,
   output logic [31:1]     ret_pc,
   output logic            ret_fault,
   output logic            ret_illegal
);
   import dec_pkg::*;

   logic            dbg_take;
   instr_u          dbg_instr;
   logic            dbg_wdata_rs1;
   logic            dbg_unsup;       // combinational reject, delayed in ib_ctl
   logic            illegal;
   logic            dfence_hit;
   logic [4:0]      rs1_addr;
   logic [4:0]      rs2_addr;
   logic [4:0]      rd_addr;
   logic            gpr_we;
   logic [11:0]     csr_addr;
   logic            csr_we;
   logic            csr_re;
   logic            sel_csr;
   logic [XLEN-1:0] rs1_data;
   logic [XLEN-1:0] rs2_data;
   logic [XLEN-1:0] csr_rdata;
   logic [XLEN-1:0] rs1_val;

   dec_slot_if #(.XLEN(XLEN)) slot ();

   dec_dbg_xlate u_xlate (
      .dbg_cmd_valid  (dbg_cmd_valid),
      .dbg_cmd_write  (dbg_cmd_write),
      .dbg_cmd_type   (dbg_type_e'(dbg_cmd_type)),
      .dbg_cmd_addr   (dbg_cmd_addr),
      .dbg_take       (dbg_take),
      .dbg_instr      (dbg_instr),
      .dbg_wdata_rs1  (dbg_wdata_rs1),
      .dbg_unsupported(dbg_unsup)
   );

   dec_ib_ctl #(.XLEN(XLEN)) u_ib_ctl (
      .clk              (clk),
      .rst_n            (rst_n),
      .ifu_valid        (ifu_valid),
      .ifu_instr        (ifu_instr),
      .ifu_pc           (ifu_pc),
      .ifu_pc4          (ifu_pc4),
      .ifu_icaf         (ifu_icaf),
      .ifu_dbecc        (ifu_dbecc),
      .dbg_take         (dbg_take),
      .dbg_instr        (dbg_instr),
      .dbg_wdata_rs1    (dbg_wdata_rs1),
      .dbg_unsupported  (dbg_unsup),
      .dbg_wdata        (dbg_wdata),
      .illegal          (illegal),
      .dfence_hit       (dfence_hit),
      .slot             (slot.ctl),
      .ret_valid        (ret_valid),
      .ret_pc           (ret_pc),
      .ret_fault        (ret_fault),
      .ret_illegal      (ret_illegal),
      .dbg_resp_valid   (dbg_resp_valid),
      .dbg_fence        (dbg_fence),
      .dbg_unsupported_d(dbg_unsupported)
   );

   dec_instr_decode u_decode (
      .slot    (slot.dec),
      .rs1_addr(rs1_addr),
      .rs2_addr(rs2_addr),
      .rd_addr (rd_addr),
      .gpr_we  (gpr_we),
      .csr_addr(csr_addr),
      .csr_we  (csr_we),
      .csr_re  (csr_re),
      .sel_csr (sel_csr),
      .illegal (illegal)
   );

   // result feeds both the gpr write port and the debug read data
   dec_gpr #(.XLEN(XLEN)) u_gpr (
      .clk     (clk),
      .rst_n   (rst_n),
      .rs1_addr(rs1_addr),
      .rs2_addr(rs2_addr),
      .rd_addr (rd_addr),
      .we      (gpr_we),
      .wdata   (dbg_rdata),
      .rs1_data(rs1_data),
      .rs2_data(rs2_data)
   );

   dec_csr #(.XLEN(XLEN)) u_csr (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (csr_addr),
      .we        (csr_we),
      .re        (csr_re),
      .wdata     (rs1_val),
      .rdata     (csr_rdata),
      .dfence_hit(dfence_hit)
   );

   dec_alu #(.XLEN(XLEN)) u_alu (
      .slot     (slot.dec),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .csr_rdata(csr_rdata),
      .sel_csr  (sel_csr),
      .rs1_val  (rs1_val),
      .result   (dbg_rdata)
   );

endmodule

// ==== test/tb_dec.sv ====
// testbench for the decode front end
// stimulus table of debug commands and fetches, shadow gpr / csr model,
// clock, reset, watchdog and a single compare task
`timescale 1ns/10ps

module tb_dec;

   localparam int         XLEN   = 32;
   localparam int         MAX_E  = 64;
   localparam logic [1:0] T_GPR  = 2'd0;
   localparam logic [1:0] T_CSR  = 2'd1;
   localparam logic [1:0] T_MEM  = 2'd2;
   // expected strobes {resp, ret, fault, illegal, fence, unsupported}
   localparam logic [5:0] E_NONE = 6'b000000;
   localparam logic [5:0] E_RESP = 6'b100000;
   localparam logic [5:0] E_RET  = 6'b010000;
   localparam logic [5:0] E_FLT  = 6'b001000;
   localparam logic [5:0] E_ILL  = 6'b000100;
   localparam logic [5:0] E_FNC  = 6'b000010;
   localparam logic [5:0] E_UNS  = 6'b000001;

   logic            clk;
   logic            rst_n;
   logic            ifu_valid;
   logic [31:0]     ifu_instr;
   logic [31:1]     ifu_pc;
   logic            ifu_pc4;
   logic            ifu_icaf;
   logic            ifu_dbecc;
   logic            dbg_cmd_valid;
   logic            dbg_cmd_write;
   logic [1:0]      dbg_cmd_type;
   logic [11:0]     dbg_cmd_addr;
   logic [XLEN-1:0] dbg_wdata;
   logic            dbg_resp_valid;
   logic [XLEN-1:0] dbg_rdata;
   logic            dbg_fence;
   logic            dbg_unsupported;
   logic            ret_valid;
   logic [31:1]     ret_pc;
   logic            ret_fault;
   logic            ret_illegal;

   // stimulus table, one entry per cycle
   string       t_name [MAX_E];
   logic        t_dv   [MAX_E];
   logic        t_dw   [MAX_E];
   logic [1:0]  t_dt   [MAX_E];
   logic [11:0] t_da   [MAX_E];
   logic        t_fv   [MAX_E];
   logic [31:0] t_fi   [MAX_E];
   logic [31:1] t_fpc  [MAX_E];
   logic [1:0]  t_flt  [MAX_E];  // {icaf, dbecc}
   logic [31:0] t_wd   [MAX_E];
   logic [5:0]  t_exp  [MAX_E];
   int          n_entries = 0;
   integer      seed = 54;

   logic [31:0] gpr_m [0:31];  // shadow register file, x0 never written
   logic [31:0] csr_m [0:3];   // mscratch, mepc, dcsr, dpc

   dec_top #(.XLEN(XLEN)) u_dut (
      .clk(clk), .rst_n(rst_n),
      .ifu_valid(ifu_valid), .ifu_instr(ifu_instr), .ifu_pc(ifu_pc),
      .ifu_pc4(ifu_pc4), .ifu_icaf(ifu_icaf), .ifu_dbecc(ifu_dbecc),
      .dbg_cmd_valid(dbg_cmd_valid), .dbg_cmd_write(dbg_cmd_write),
      .dbg_cmd_type(dbg_cmd_type), .dbg_cmd_addr(dbg_cmd_addr), .dbg_wdata(dbg_wdata),
      .dbg_resp_valid(dbg_resp_valid), .dbg_rdata(dbg_rdata), .dbg_fence(dbg_fence),
      .dbg_unsupported(dbg_unsupported), .ret_valid(ret_valid), .ret_pc(ret_pc),
      .ret_fault(ret_fault), .ret_illegal(ret_illegal)
   );

   always #5 clk = ~clk;  // 10 ns period

   // or rd, rs1, rs2 in the standard r-type encoding
   function automatic logic [31:0] or_instr(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
      return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
   endfunction

   function automatic int csr_index(input logic [11:0] addr);
      case (addr)
         12'h340: return 0;
         12'h341: return 1;
         12'h7b0: return 2;
         12'h7b1: return 3;
         default: return -1;  // not implemented, reads zero
      endcase
   endfunction

   task automatic check(input string name, input string field, input logic [31:0] exp,
                        input logic [31:0] act);
      if (act !== exp) begin
         $display("[ERROR] %s (%s): expected %h, actual %h", name, field, exp, act);
         $display("sim failed");
         $fatal(1);
      end
   endtask

   task automatic put_entry(input string name, input logic dv, input logic dw,
                            input logic [1:0] dt, input logic [11:0] da, input logic fv,
                            input logic [31:0] fi, input logic [31:1] fpc,
                            input logic [1:0] flt, input logic [5:0] exp);
      t_name[n_entries] = name;
      t_dv[n_entries]   = dv;
      t_dw[n_entries]   = dw;
      t_dt[n_entries]   = dt;
      t_da[n_entries]   = da;
      t_fv[n_entries]   = fv;
      t_fi[n_entries]   = fi;
      t_fpc[n_entries]  = fpc;
      t_flt[n_entries]  = flt;
      t_wd[n_entries]   = $random(seed);  // unused unless the entry is a write
      t_exp[n_entries]  = exp;
      n_entries++;
   endtask

   task automatic dbg_entry(input string name, input logic dw, input logic [1:0] dt,
                            input logic [11:0] da, input logic [5:0] exp);
      put_entry(name, 1'b1, dw, dt, da, 1'b0, 32'd0, 31'd0, 2'b00, exp);
   endtask

   task automatic fetch_entry(input string name, input logic [31:0] fi,
                              input logic [31:1] fpc, input logic [1:0] flt,
                              input logic [5:0] exp);
      put_entry(name, 1'b0, 1'b0, T_GPR, 12'd0, 1'b1, fi, fpc, flt, exp);
   endtask

   task automatic build_table();
      dbg_entry("gpr_wr_x5", 1, T_GPR, 12'd5, E_RESP);
      dbg_entry("gpr_rd_x5", 0, T_GPR, 12'd5, E_RESP);
      dbg_entry("gpr_wr_x0", 1, T_GPR, 12'd0, E_RESP);
      dbg_entry("gpr_rd_x0", 0, T_GPR, 12'd0, E_RESP);   // must stay zero
      dbg_entry("gpr_wr_x6", 1, T_GPR, 12'd6, E_RESP);
      dbg_entry("gpr_wr_x7", 1, T_GPR, 12'd7, E_RESP);
      fetch_entry("fetch_or_x8", or_instr(8, 6, 7), 31'h80, 2'b00, E_RET);
      dbg_entry("gpr_rd_x8", 0, T_GPR, 12'd8, E_RESP);
      fetch_entry("fetch_illegal", 32'h0000_0013, 31'h82, 2'b00, E_RET | E_ILL);
      fetch_entry("fetch_icaf", or_instr(5, 6, 7), 31'h84, 2'b10, E_RET | E_FLT);
      fetch_entry("fetch_dbecc", or_instr(5, 6, 0), 31'h86, 2'b01, E_RET | E_FLT);
      dbg_entry("gpr_rd_x5_kept", 0, T_GPR, 12'd5, E_RESP);
      dbg_entry("csr_wr_mscratch", 1, T_CSR, 12'h340, E_RESP);
      dbg_entry("csr_wr_mepc", 1, T_CSR, 12'h341, E_RESP);
      dbg_entry("csr_wr_dcsr", 1, T_CSR, 12'h7b0, E_RESP);
      dbg_entry("csr_wr_dpc", 1, T_CSR, 12'h7b1, E_RESP);
      dbg_entry("csr_rd_mscratch", 0, T_CSR, 12'h340, E_RESP);
      dbg_entry("csr_rd_mepc", 0, T_CSR, 12'h341, E_RESP);
      dbg_entry("csr_rd_dcsr", 0, T_CSR, 12'h7b0, E_RESP);
      dbg_entry("csr_rd_dpc", 0, T_CSR, 12'h7b1, E_RESP);
      dbg_entry("csr_wr_unknown", 1, T_CSR, 12'h123, E_RESP);
      dbg_entry("csr_rd_unknown", 0, T_CSR, 12'h123, E_RESP);
      dbg_entry("csr_wr_fence", 1, T_CSR, 12'h7c4, E_RESP | E_FNC);
      dbg_entry("csr_rd_fence", 0, T_CSR, 12'h7c4, E_RESP);  // read alone, no pulse
      dbg_entry("csr_rewr_mscratch", 1, T_CSR, 12'h340, E_RESP);  // returns old value
      // debug and fetch together, fetch is dropped and x9 untouched
      put_entry("dbg_beats_fetch", 1, 0, T_GPR, 12'd8, 1, or_instr(9, 5, 6), 31'h88,
                2'b00, E_RESP);
      dbg_entry("gpr_rd_x9", 0, T_GPR, 12'd9, E_RESP);
      dbg_entry("mem_cmd", 1, T_MEM, 12'd0, E_UNS);
      dbg_entry("gpr_rd_x8_again", 0, T_GPR, 12'd8, E_RESP);
   endtask

   task automatic drive_idle();
      ifu_valid     = 1'b0;
      ifu_instr     = 32'd0;
      ifu_pc        = 31'd0;
      ifu_pc4       = 1'b0;
      ifu_icaf      = 1'b0;
      ifu_dbecc     = 1'b0;
      dbg_cmd_valid = 1'b0;
      dbg_cmd_write = 1'b0;
      dbg_cmd_type  = 2'd0;
      dbg_cmd_addr  = 12'd0;
      dbg_wdata     = '0;
   endtask

   task automatic drive_entry(input int k);
      ifu_valid     = t_fv[k];
      ifu_instr     = t_fi[k];
      ifu_pc        = t_fpc[k];
      ifu_icaf      = t_flt[k][1];
      ifu_dbecc     = t_flt[k][0];
      dbg_cmd_valid = t_dv[k];
      dbg_cmd_write = t_dw[k];
      dbg_cmd_type  = t_dt[k];
      dbg_cmd_addr  = t_da[k];
      dbg_wdata     = t_wd[k];
   endtask

   // compare the response cycle of entry k and advance the shadow state
   task automatic check_entry(input int k);
      logic [31:0] exp_rd;
      logic [31:0] fi;
      logic [4:0]  r;
      int          idx;
      check(t_name[k], "strobes", {26'd0, t_exp[k]},
            {26'd0, dbg_resp_valid, ret_valid, ret_fault, ret_illegal, dbg_fence,
             dbg_unsupported});
      fi = t_fi[k];
      r  = t_da[k][4:0];
      if (t_dv[k] && t_dt[k] == T_GPR) begin
         exp_rd = t_dw[k] ? t_wd[k] : gpr_m[r];  // write echoes its data
         if (t_dw[k] && r != 5'd0)
            gpr_m[r] = t_wd[k];
         check(t_name[k], "dbg_rdata", exp_rd, dbg_rdata);
      end else if (t_dv[k] && t_dt[k] == T_CSR) begin
         idx    = csr_index(t_da[k]);
         exp_rd = (idx >= 0) ? csr_m[idx] : 32'd0;  // old value comes back
         if (t_dw[k] && idx >= 0)
            csr_m[idx] = t_wd[k];
         check(t_name[k], "dbg_rdata", exp_rd, dbg_rdata);
      end else if (!t_dv[k] && t_fv[k]) begin
         check(t_name[k], "ret_pc", {1'b0, t_fpc[k]}, {1'b0, ret_pc});
         // legal or without a fault updates rd
         if (t_flt[k] == 2'b00 && fi[6:0] == 7'b0110011 && fi[14:12] == 3'b110 &&
             fi[31:25] == 7'd0 && fi[11:7] != 5'd0)
            gpr_m[fi[11:7]] = gpr_m[fi[19:15]] | gpr_m[fi[24:20]];
      end
   endtask

   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      drive_idle();
      for (int i = 0; i < 32; i++)
         gpr_m[i] = 32'd0;
      for (int i = 0; i < 4; i++)
         csr_m[i] = 32'd0;
      build_table();
      repeat (2) @(posedge clk);
      #1 rst_n = 1'b1;
      for (int i = 0; i <= n_entries; i++) begin
         @(posedge clk);
         #1;                           // drive just after the edge
         if (i < n_entries)
            drive_entry(i);
         else
            drive_idle();
         @(negedge clk);               // outputs of entry i-1 are settled here
         if (i == 0)
            check("after_reset", "strobes", {26'd0, E_NONE},
                  {26'd0, dbg_resp_valid, ret_valid, ret_fault, ret_illegal, dbg_fence,
                   dbg_unsupported});
         else
            check_entry(i - 1);
      end
      $display("sim passed");
      $finish;
   end

   // watchdog, table length plus margin in clock periods
   initial begin
      wait (n_entries > 0);
      #((n_entries + 20) * 10);
      $display("watchdog expired before the stimulus table finished");
      $display("sim failed");
      $fatal(1);
   end

endmodule
